//--- verilog/bridge_pkg.sv
package bridge_pkg;

  localparam int addr_w     = 32;
  localparam int data_w     = 32;
  localparam int line_w     = 128;
  localparam int line_beats = 4;
  localparam int len_w      = 8;
  localparam int id_w       = 4;

  // read ids, one per requester
  localparam logic [id_w-1:0] id_inst = id_w'(0);
  localparam logic [id_w-1:0] id_data = id_w'(1);

  // burst length field for a full cache line
  localparam logic [len_w-1:0] line_len = len_w'(line_beats - 1);

  // request size as seen on rd_type and wr_type
  typedef enum logic [2:0] {
    type_byte = 3'd0,
    type_half = 3'd1,
    type_word = 3'd2,
    type_line = 3'd4
  } req_type_e;

  typedef enum logic [1:0] {
    wr_idle,
    wr_addr,
    wr_data,
    wr_resp
  } wr_state_e;

endpackage

//--- verilog/read_arbiter.sv
`timescale 1ns/100ps

module read_arbiter (
  input  logic                          aclk,
  input  logic                          arst_n,
  input  logic                          inst_rd_req,
  input  bridge_pkg::req_type_e         inst_rd_type,
  input  logic [bridge_pkg::addr_w-1:0] inst_rd_addr,
  input  logic                          data_rd_req,
  input  bridge_pkg::req_type_e         data_rd_type,
  input  logic [bridge_pkg::addr_w-1:0] data_rd_addr,
  input  logic                          inst_busy,
  input  logic                          data_busy,
  input  logic                          wr_busy,
  output logic                          inst_rd_rdy,
  output logic                          data_rd_rdy,
  output logic                          inst_grant,
  output logic                          data_grant,
  output logic [bridge_pkg::id_w-1:0]   arid,
  output logic [bridge_pkg::addr_w-1:0] araddr,
  output logic [bridge_pkg::len_w-1:0]  arlen,
  output logic [2:0]                    arsize,
  output logic                          arvalid,
  input  logic                          arready
);

  bridge_pkg::req_type_e sel_type;

  // data reads are held back while a write is still in flight
  assign data_rd_rdy = !arvalid && !data_busy && !wr_busy;
  // data has priority when both ask
  assign inst_rd_rdy = !arvalid && !inst_busy && !(data_rd_req && data_rd_rdy);

  assign data_grant = data_rd_req && data_rd_rdy;
  assign inst_grant = inst_rd_req && inst_rd_rdy;

  assign sel_type = data_grant ? data_rd_type : inst_rd_type;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      arvalid <= 1'b0;
    end else if (data_grant || inst_grant) begin
      arvalid <= 1'b1;
    end else if (arready) begin
      arvalid <= 1'b0;
    end
  end

  // payload only loads while the AR register is empty
  always_ff @(posedge aclk) begin
    if (data_grant || inst_grant) begin
      arid   <= data_grant ? bridge_pkg::id_data : bridge_pkg::id_inst;
      araddr <= data_grant ? data_rd_addr : inst_rd_addr;
      if (sel_type == bridge_pkg::type_line) begin
        arlen  <= bridge_pkg::line_len;
        arsize <= 3'd2;
      end else begin
        arlen  <= '0;
        arsize <= {1'b0, sel_type[1:0]};
      end
    end
  end

endmodule

//--- verilog/read_return.sv
`timescale 1ns/100ps

module read_return (
  input  logic                          aclk,
  input  logic                          arst_n,
  input  logic                          inst_grant,
  input  logic                          data_grant,
  input  logic [bridge_pkg::id_w-1:0]   rid,
  input  logic [bridge_pkg::data_w-1:0] rdata,
  input  logic                          rlast,
  input  logic                          rvalid,
  output logic                          rready,
  output logic                          inst_busy,
  output logic                          data_busy,
  output logic                          inst_ret_valid,
  output logic                          inst_ret_last,
  output logic [bridge_pkg::data_w-1:0] inst_ret_data,
  output logic                          data_ret_valid,
  output logic                          data_ret_last,
  output logic [bridge_pkg::data_w-1:0] data_ret_data
);

  logic beat;

  assign rready = inst_busy || data_busy;
  assign beat   = rvalid && rready;

  // steer by id, same cycle as the R handshake
  assign inst_ret_valid = beat && (rid == bridge_pkg::id_inst);
  assign data_ret_valid = beat && (rid == bridge_pkg::id_data);
  assign inst_ret_last  = inst_ret_valid && rlast;
  assign data_ret_last  = data_ret_valid && rlast;
  assign inst_ret_data  = rdata;
  assign data_ret_data  = rdata;

  // one outstanding read per port, grant never overlaps the last beat
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      inst_busy <= 1'b0;
      data_busy <= 1'b0;
    end else begin
      if (inst_grant) begin
        inst_busy <= 1'b1;
      end else if (inst_ret_last) begin
        inst_busy <= 1'b0;
      end
      if (data_grant) begin
        data_busy <= 1'b1;
      end else if (data_ret_last) begin
        data_busy <= 1'b0;
      end
    end
  end

endmodule

//--- verilog/write_sequencer.sv
`timescale 1ns/100ps

module write_sequencer (
  input  logic                            aclk,
  input  logic                            arst_n,
  input  logic                            data_wr_req,
  input  bridge_pkg::req_type_e           data_wr_type,
  input  logic [bridge_pkg::addr_w-1:0]   data_wr_addr,
  input  logic [bridge_pkg::data_w/8-1:0] data_wr_wstrb,
  input  logic [bridge_pkg::line_w-1:0]   data_wr_data,
  output logic                            data_wr_rdy,
  output logic                            wr_busy,
  output logic [bridge_pkg::addr_w-1:0]   awaddr,
  output logic [bridge_pkg::len_w-1:0]    awlen,
  output logic [2:0]                      awsize,
  output logic                            awvalid,
  input  logic                            awready,
  output logic [bridge_pkg::data_w-1:0]   wdata,
  output logic [bridge_pkg::data_w/8-1:0] wstrb,
  output logic                            wlast,
  output logic                            wvalid,
  input  logic                            wready,
  input  logic                            bvalid,
  output logic                            bready
);

  bridge_pkg::wr_state_e             state;
  logic [bridge_pkg::len_w-1:0]      beat_cnt;
  logic [bridge_pkg::line_w-1:0]     line_q;
  logic                              accept;
  logic                              w_beat;

  assign data_wr_rdy = (state == bridge_pkg::wr_idle);
  assign wr_busy     = !data_wr_rdy;
  assign accept      = data_wr_req && data_wr_rdy;

  assign awvalid = (state == bridge_pkg::wr_addr);
  assign wvalid  = (state == bridge_pkg::wr_data);
  assign bready  = (state == bridge_pkg::wr_resp);
  assign w_beat  = wvalid && wready;

  // low word of the shifted line is always the current beat
  assign wdata = line_q[bridge_pkg::data_w-1:0];
  assign wlast = wvalid && (beat_cnt == awlen);

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= bridge_pkg::wr_idle;
      beat_cnt <= '0;
    end else begin
      unique case (state)
        bridge_pkg::wr_idle: begin
          if (accept) begin
            state    <= bridge_pkg::wr_addr;
            beat_cnt <= '0;
          end
        end
        bridge_pkg::wr_addr: begin
          if (awready) state <= bridge_pkg::wr_data;
        end
        bridge_pkg::wr_data: begin
          if (w_beat) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (wlast) state <= bridge_pkg::wr_resp;
          end
        end
        bridge_pkg::wr_resp: begin
          if (bvalid) state <= bridge_pkg::wr_idle;
        end
        default: state <= bridge_pkg::wr_idle;
      endcase
    end
  end

  // captured request, shifted one word per accepted W beat
  always_ff @(posedge aclk) begin
    if (accept) begin
      awaddr <= data_wr_addr;
      line_q <= data_wr_data;
      if (data_wr_type == bridge_pkg::type_line) begin
        awlen  <= bridge_pkg::line_len;
        awsize <= 3'd2;
        wstrb  <= '1;
      end else begin
        awlen  <= '0;
        awsize <= {1'b0, data_wr_type[1:0]};
        wstrb  <= data_wr_wstrb;
      end
    end else if (w_beat) begin
      line_q <= line_q >> bridge_pkg::data_w;
    end
  end

endmodule

//--- verilog/axi_bridge_top.sv
`timescale 1ns/100ps

module axi_bridge_top (
  input  logic                            aclk,
  input  logic                            arst_n,
  // instruction port
  input  logic                            inst_rd_req,
  input  bridge_pkg::req_type_e           inst_rd_type,
  input  logic [bridge_pkg::addr_w-1:0]   inst_rd_addr,
  output logic                            inst_rd_rdy,
  output logic                            inst_ret_valid,
  output logic                            inst_ret_last,
  output logic [bridge_pkg::data_w-1:0]   inst_ret_data,
  // data port
  input  logic                            data_rd_req,
  input  bridge_pkg::req_type_e           data_rd_type,
  input  logic [bridge_pkg::addr_w-1:0]   data_rd_addr,
  output logic                            data_rd_rdy,
  output logic                            data_ret_valid,
  output logic                            data_ret_last,
  output logic [bridge_pkg::data_w-1:0]   data_ret_data,
  input  logic                            data_wr_req,
  input  bridge_pkg::req_type_e           data_wr_type,
  input  logic [bridge_pkg::addr_w-1:0]   data_wr_addr,
  input  logic [bridge_pkg::data_w/8-1:0] data_wr_wstrb,
  input  logic [bridge_pkg::line_w-1:0]   data_wr_data,
  output logic                            data_wr_rdy,
  // AXI read
  output logic [bridge_pkg::id_w-1:0]     arid,
  output logic [bridge_pkg::addr_w-1:0]   araddr,
  output logic [bridge_pkg::len_w-1:0]    arlen,
  output logic [2:0]                      arsize,
  output logic                            arvalid,
  input  logic                            arready,
  input  logic [bridge_pkg::id_w-1:0]     rid,
  input  logic [bridge_pkg::data_w-1:0]   rdata,
  input  logic                            rlast,
  input  logic                            rvalid,
  output logic                            rready,
  // AXI write
  output logic [bridge_pkg::addr_w-1:0]   awaddr,
  output logic [bridge_pkg::len_w-1:0]    awlen,
  output logic [2:0]                      awsize,
  output logic                            awvalid,
  input  logic                            awready,
  output logic [bridge_pkg::data_w-1:0]   wdata,
  output logic [bridge_pkg::data_w/8-1:0] wstrb,
  output logic                            wlast,
  output logic                            wvalid,
  input  logic                            wready,
  input  logic                            bvalid,
  output logic                            bready
);

  logic inst_busy;
  logic data_busy;
  logic wr_busy;
  logic inst_grant;
  logic data_grant;

  read_arbiter u_read_arbiter (
    .aclk         (aclk),
    .arst_n       (arst_n),
    .inst_rd_req  (inst_rd_req),
    .inst_rd_type (inst_rd_type),
    .inst_rd_addr (inst_rd_addr),
    .data_rd_req  (data_rd_req),
    .data_rd_type (data_rd_type),
    .data_rd_addr (data_rd_addr),
    .inst_busy    (inst_busy),
    .data_busy    (data_busy),
    .wr_busy      (wr_busy),
    .inst_rd_rdy  (inst_rd_rdy),
    .data_rd_rdy  (data_rd_rdy),
    .inst_grant   (inst_grant),
    .data_grant   (data_grant),
    .arid         (arid),
    .araddr       (araddr),
    .arlen        (arlen),
    .arsize       (arsize),
    .arvalid      (arvalid),
    .arready      (arready)
  );

  read_return u_read_return (
    .aclk           (aclk),
    .arst_n         (arst_n),
    .inst_grant     (inst_grant),
    .data_grant     (data_grant),
    .rid            (rid),
    .rdata          (rdata),
    .rlast          (rlast),
    .rvalid         (rvalid),
    .rready         (rready),
    .inst_busy      (inst_busy),
    .data_busy      (data_busy),
    .inst_ret_valid (inst_ret_valid),
    .inst_ret_last  (inst_ret_last),
    .inst_ret_data  (inst_ret_data),
    .data_ret_valid (data_ret_valid),
    .data_ret_last  (data_ret_last),
    .data_ret_data  (data_ret_data)
  );

  write_sequencer u_write_sequencer (
    .aclk          (aclk),
    .arst_n        (arst_n),
    .data_wr_req   (data_wr_req),
    .data_wr_type  (data_wr_type),
    .data_wr_addr  (data_wr_addr),
    .data_wr_wstrb (data_wr_wstrb),
    .data_wr_data  (data_wr_data),
    .data_wr_rdy   (data_wr_rdy),
    .wr_busy       (wr_busy),
    .awaddr        (awaddr),
    .awlen         (awlen),
    .awsize        (awsize),
    .awvalid       (awvalid),
    .awready       (awready),
    .wdata         (wdata),
    .wstrb         (wstrb),
    .wlast         (wlast),
    .wvalid        (wvalid),
    .wready        (wready),
    .bvalid        (bvalid),
    .bready        (bready)
  );

endmodule

//--- testbench/axi_bridge_properties.sv
`timescale 1ns/100ps

module axi_bridge_properties (
  input logic        aclk, arst_n,
  input logic        arvalid, arready, awvalid, awready, wvalid, wready,
  input logic [31:0] araddr, wdata,
  input logic        inst_rd_req, inst_rd_rdy, data_rd_req, data_rd_rdy
);

  // a waiting AR keeps its address
  ar_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("arvalid or araddr changed before arready");

  aw_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    awvalid && !awready |=> awvalid)
    else $error("awvalid dropped before awready");

  w_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    wvalid && !wready |=> wvalid && $stable(wdata))
    else $error("wvalid or wdata changed before wready");

  one_grant: assert property (@(posedge aclk) disable iff (!arst_n)
    !(inst_rd_req && inst_rd_rdy && data_rd_req && data_rd_rdy))
    else $error("both read ports granted in the same cycle");

endmodule

bind axi_bridge_top axi_bridge_properties u_props (.*);

//--- testbench/tb_axi_bridge.sv
`timescale 1ns/100ps

module tb_axi_bridge;

  localparam logic [31:0] rd_key = 32'h5a5a_0f0f;
  localparam int max_cycles = 2000;

  logic aclk = 1'b0;
  logic arst_n, inst_rd_req, data_rd_req, data_wr_req;
  logic inst_rd_rdy, data_rd_rdy, data_wr_rdy, inst_ret_valid, inst_ret_last;
  logic data_ret_valid, data_ret_last, arvalid, rready, awvalid, wvalid, wlast, bready;
  bridge_pkg::req_type_e inst_rd_type, data_rd_type, data_wr_type;
  logic [31:0] inst_rd_addr, data_rd_addr, data_wr_addr, inst_ret_data, data_ret_data;
  logic [31:0] araddr, awaddr, wdata;
  logic [3:0] data_wr_wstrb, wstrb, arid;
  logic [127:0] data_wr_data;
  logic [7:0] arlen, awlen;
  logic [2:0] arsize, awsize;
  // slave side outputs
  logic arready = 1'b0, awready = 1'b0, wready = 1'b0, rvalid = 1'b0, bvalid = 1'b0;
  logic rlast = 1'b0;
  logic [3:0] rid = 4'd0;
  logic [31:0] rdata = 32'd0;
  logic [31:0] slave_seed = 32'd11, stim_seed = 32'd11;
  logic [3:0] ar_id_q[$];
  logic [31:0] ar_addr_q[$];
  logic [7:0] ar_len_q[$];
  logic [7:0] r_idx = 8'd0;
  logic r_taken = 1'b0, b_taken = 1'b0, b_due = 1'b0;
  // expected state per port
  logic inst_pend = 1'b0, data_pend = 1'b0, wr_pend = 1'b0, ar_pend = 1'b0;
  logic [31:0] inst_addr, data_addr;
  logic [7:0] inst_len, data_len, inst_idx, data_idx, w_len, w_idx;
  logic [127:0] w_line;
  logic [3:0] w_strb;
  // expected AR and AW payloads
  logic [3:0] ar_id_exp;
  logic [31:0] ar_addr_exp, aw_addr_exp;
  logic [7:0] ar_len_exp;
  logic [2:0] ar_size_exp, aw_size_exp;
  int cycles = 0;

  axi_bridge_top uut (.*);

  always #2 aclk = ~aclk;

  function automatic logic [31:0] lcg_step(logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] next_stim();
    stim_seed = lcg_step(stim_seed);
    return stim_seed;
  endfunction

  function automatic logic [31:0] beat_word(logic [31:0] addr, logic [7:0] idx);
    return (addr + {22'd0, idx, 2'b00}) ^ rd_key;
  endfunction

  function automatic logic [7:0] last_index(bridge_pkg::req_type_e t);
    return (t == bridge_pkg::type_line) ? 8'd3 : 8'd0;
  endfunction

  // a line moves as words
  function automatic logic [2:0] size_code(bridge_pkg::req_type_e t);
    case (t)
      bridge_pkg::type_byte: return 3'd0;
      bridge_pkg::type_half: return 3'd1;
      default:               return 3'd2;
    endcase
  endfunction

  function automatic bridge_pkg::req_type_e type_of(logic [1:0] r);
    return (r == 2'd3) ? bridge_pkg::type_line : bridge_pkg::req_type_e'({1'b0, r});
  endfunction

  task automatic fail_value(string name, logic [31:0] exp, logic [31:0] act);
    $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
    $display("Errors found");
    $fatal(1, "value mismatch");
  endtask

  task automatic fail_event(string what);
    $display("%0t %s", $time, what);
    $display("Errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic expect_low(string name, logic val);
    assert (val == 1'b0) else fail_value(name, 32'd0, 32'(val));
  endtask

  task automatic inst_read(bridge_pkg::req_type_e t, logic [31:0] addr);
    @(negedge aclk);
    inst_rd_req = 1'b1;
    inst_rd_type = t;
    inst_rd_addr = addr;
    @(posedge aclk);
    while (!inst_rd_rdy) @(posedge aclk);
    @(negedge aclk);
    inst_rd_req = 1'b0;
  endtask

  task automatic data_read(bridge_pkg::req_type_e t, logic [31:0] addr);
    @(negedge aclk);
    data_rd_req = 1'b1;
    data_rd_type = t;
    data_rd_addr = addr;
    @(posedge aclk);
    while (!data_rd_rdy) @(posedge aclk);
    @(negedge aclk);
    data_rd_req = 1'b0;
  endtask

  task automatic data_write(bridge_pkg::req_type_e t, logic [31:0] addr, logic [3:0] strb,
                            logic [127:0] line);
    @(negedge aclk);
    data_wr_req = 1'b1;
    data_wr_type = t;
    data_wr_addr = addr;
    data_wr_wstrb = strb;
    data_wr_data = line;
    @(posedge aclk);
    while (!data_wr_rdy) @(posedge aclk);
    @(negedge aclk);
    data_wr_req = 1'b0;
  endtask

  task automatic wait_idle();
    wait (!inst_pend && !data_pend && !wr_pend);
  endtask

  // slave records handshakes at the rising edge
  always @(posedge aclk) begin
    r_taken <= rvalid && rready;
    b_taken <= bvalid && bready;
    if (arvalid && arready) begin
      ar_id_q.push_back(arid);
      ar_addr_q.push_back(araddr);
      ar_len_q.push_back(arlen);
    end
    if (rvalid && rready) begin
      r_idx <= rlast ? 8'd0 : r_idx + 8'd1;
      if (rlast) begin
        ar_id_q.delete(0);
        ar_addr_q.delete(0);
        ar_len_q.delete(0);
      end
    end
    if (wvalid && wready && wlast) b_due <= 1'b1;
    else if (bvalid && bready) b_due <= 1'b0;
  end

  always @(negedge aclk) begin
    slave_seed = lcg_step(slave_seed);
    arready = slave_seed[16];
    awready = slave_seed[17];
    wready = slave_seed[18] | slave_seed[19];
    // an offered beat stays until taken
    if (!rvalid || r_taken) begin
      rvalid = (ar_id_q.size() > 0) && slave_seed[20];
      if (rvalid) begin
        rid = ar_id_q[0];
        rdata = beat_word(ar_addr_q[0], r_idx);
        rlast = (r_idx == ar_len_q[0]);
      end
    end
    if (!bvalid || b_taken) bvalid = b_due && slave_seed[21];
  end

  always @(posedge aclk) begin
    logic d_rdy_exp;
    logic i_rdy_exp;
    cycles = cycles + 1;
    if (cycles >= max_cycles) fail_event("timeout, the tests did not finish in time");
    if (arst_n) begin
      // data first, both wait for an empty AR register
      d_rdy_exp = !ar_pend && !data_pend && !wr_pend;
      i_rdy_exp = !ar_pend && !inst_pend && !(data_rd_req && d_rdy_exp);
      assert (arvalid == ar_pend) else fail_value("arvalid", 32'(ar_pend), 32'(arvalid));
      assert (data_rd_rdy == d_rdy_exp)
        else fail_value("data_rd_rdy", 32'(d_rdy_exp), 32'(data_rd_rdy));
      assert (inst_rd_rdy == i_rdy_exp)
        else fail_value("inst_rd_rdy", 32'(i_rdy_exp), 32'(inst_rd_rdy));
      assert (data_wr_rdy == !wr_pend)
        else fail_value("data_wr_rdy", 32'(!wr_pend), 32'(data_wr_rdy));
      assert (rready == (inst_pend || data_pend))
        else fail_value("rready", 32'(inst_pend || data_pend), 32'(rready));
      if (arvalid && arready) begin
        assert (arid == ar_id_exp) else fail_value("arid", 32'(ar_id_exp), 32'(arid));
        assert (araddr == ar_addr_exp) else fail_value("araddr", ar_addr_exp, araddr);
        assert (arlen == ar_len_exp) else fail_value("arlen", 32'(ar_len_exp), 32'(arlen));
        assert (arsize == ar_size_exp)
          else fail_value("arsize", 32'(ar_size_exp), 32'(arsize));
        ar_pend = 1'b0;
      end
      if (inst_rd_req && inst_rd_rdy) begin
        inst_pend = 1'b1;
        inst_addr = inst_rd_addr;
        inst_len = last_index(inst_rd_type);
        inst_idx = 8'd0;
        ar_pend = 1'b1;
        ar_id_exp = bridge_pkg::id_inst;
        ar_addr_exp = inst_rd_addr;
        ar_len_exp = inst_len;
        ar_size_exp = size_code(inst_rd_type);
      end
      if (data_rd_req && data_rd_rdy) begin
        data_pend = 1'b1;
        data_addr = data_rd_addr;
        data_len = last_index(data_rd_type);
        data_idx = 8'd0;
        ar_pend = 1'b1;
        ar_id_exp = bridge_pkg::id_data;
        ar_addr_exp = data_rd_addr;
        ar_len_exp = data_len;
        ar_size_exp = size_code(data_rd_type);
      end
      if (inst_ret_valid) begin
        assert (inst_pend) else fail_event("instruction beat with no read outstanding");
        assert (inst_ret_data == beat_word(inst_addr, inst_idx))
          else fail_value("inst_ret_data", beat_word(inst_addr, inst_idx), inst_ret_data);
        assert (inst_ret_last == (inst_idx == inst_len))
          else fail_value("inst_ret_last", 32'(inst_idx == inst_len), 32'(inst_ret_last));
        inst_pend = !inst_ret_last;
        inst_idx = inst_idx + 8'd1;
      end
      if (data_ret_valid) begin
        assert (data_pend) else fail_event("data beat with no read outstanding");
        assert (data_ret_data == beat_word(data_addr, data_idx))
          else fail_value("data_ret_data", beat_word(data_addr, data_idx), data_ret_data);
        assert (data_ret_last == (data_idx == data_len))
          else fail_value("data_ret_last", 32'(data_idx == data_len), 32'(data_ret_last));
        data_pend = !data_ret_last;
        data_idx = data_idx + 8'd1;
      end
      if (awvalid && awready) begin
        assert (awaddr == aw_addr_exp) else fail_value("awaddr", aw_addr_exp, awaddr);
        assert (awlen == w_len) else fail_value("awlen", 32'(w_len), 32'(awlen));
        assert (awsize == aw_size_exp)
          else fail_value("awsize", 32'(aw_size_exp), 32'(awsize));
      end
      if (data_wr_req && data_wr_rdy) begin
        wr_pend = 1'b1;
        w_line = data_wr_data;
        w_strb = (data_wr_type == bridge_pkg::type_line) ? 4'hf : data_wr_wstrb;
        w_len = last_index(data_wr_type);
        w_idx = 8'd0;
        aw_addr_exp = data_wr_addr;
        aw_size_exp = size_code(data_wr_type);
      end
      if (wvalid && wready) begin
        assert (wdata == w_line[32*w_idx +: 32])
          else fail_value("wdata", w_line[32*w_idx +: 32], wdata);
        assert (wstrb == w_strb) else fail_value("wstrb", 32'(w_strb), 32'(wstrb));
        assert (wlast == (w_idx == w_len))
          else fail_value("wlast", 32'(w_idx == w_len), 32'(wlast));
        w_idx = w_idx + 8'd1;
      end
      if (bvalid && bready) wr_pend = 1'b0;
    end
  end

  initial begin
    logic [127:0] line;
    logic [31:0] r;
    arst_n = 1'b0;
    inst_rd_req = 1'b0;
    inst_rd_type = bridge_pkg::type_word;
    inst_rd_addr = 32'd0;
    data_rd_req = 1'b0;
    data_rd_type = bridge_pkg::type_word;
    data_rd_addr = 32'd0;
    data_wr_req = 1'b0;
    data_wr_type = bridge_pkg::type_word;
    data_wr_addr = 32'd0;
    data_wr_wstrb = 4'd0;
    data_wr_data = 128'd0;
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    arst_n = 1'b1;
    expect_low("arvalid", arvalid);
    expect_low("awvalid", awvalid);
    expect_low("wvalid", wvalid);
    expect_low("bready", bready);
    expect_low("rready", rready);
    inst_read(bridge_pkg::type_word, 32'h0000_0100);
    wait_idle();
    // line reads on both ports, outstanding together
    fork
      data_read(bridge_pkg::type_line, 32'h0000_0200);
      begin
        @(negedge aclk);
        inst_read(bridge_pkg::type_line, 32'h0000_0300);
      end
    join
    wait_idle();
    fork
      data_read(bridge_pkg::type_word, 32'h0000_0400);
      inst_read(bridge_pkg::type_word, 32'h0000_0500);
    join
    wait_idle();
    for (int i = 0; i < 4; i++) line[32*i +: 32] = next_stim();
    data_write(bridge_pkg::type_line, 32'h0000_1000, 4'h0, line);
    wait_idle();
    data_write(bridge_pkg::type_half, 32'h0000_1004, 4'b0110, {96'd0, next_stim()});
    wait_idle();
    // reads issued while a line write is in flight
    fork
      data_write(bridge_pkg::type_line, 32'h0000_2000, 4'h0, ~line);
      begin
        repeat (3) @(negedge aclk);
        data_read(bridge_pkg::type_word, 32'h0000_2000);
      end
      begin
        repeat (3) @(negedge aclk);
        inst_read(bridge_pkg::type_word, 32'h0000_2100);
      end
    join
    wait_idle();
    for (int n = 0; n < 16; n++) begin
      r = next_stim();
      fork
        inst_read(type_of(r[1:0]), {20'd0, r[11:4], 4'd0});
        data_read(type_of(r[3:2]), {20'd1, r[19:12], 4'd0});
      join
      if (r[20]) data_write(type_of(r[22:21]), {20'd2, r[31:24], 4'd0}, r[26:23], line);
      wait_idle();
    end
    $display("No errors");
    $finish;
  end

endmodule

//--- files.f
verilog/bridge_pkg.sv
verilog/read_arbiter.sv
verilog/read_return.sv
verilog/write_sequencer.sv
verilog/axi_bridge_top.sv
testbench/axi_bridge_properties.sv
testbench/tb_axi_bridge.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tb_axi_bridge -f files.f -o tb_sim &&
  ./obj_dir/tb_sim || exit 1
